// ==== Makefile ====
# Verilator build and run for the cpu900 core

LOG := sim.log

.PHONY: all lint clean

all: obj_dir/Vcpu900_tb
	./obj_dir/Vcpu900_tb | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

obj_dir/Vcpu900_tb: cpu900.f include/*.svh logic/*.sv verif/*.sv
	verilator --binary --timing --assert -f cpu900.f --top-module cpu900_tb

lint:
	verilator --lint-only --timing -f cpu900.f --top-module cpu900_tb

clean:
	rm -rf obj_dir $(LOG)

// ==== cpu900.f ====
+incdir+include
logic/cpu900_pkg.sv
logic/cpu900_alu.sv
logic/cpu900_seq.sv
logic/cpu900_regs.sv
logic/cpu900_core.sv
verif/cpu900_assertions.sv
verif/cpu900_tb.sv

// ==== include/cpu900_config.svh ====
/* cpu900 configuration
   register file sizes and micro-sequencer step count */

`ifndef CPU900_CONFIG_SVH
`define CPU900_CONFIG_SVH

// pointer register used as stack pointer
`define CPU900_XSP 3

// accumulators, four banks of four
`define CPU900_NACC 16

// pointer registers
`define CPU900_NPTR 4

// steps per instruction and the width of the step counter
`define CPU900_STEPS 5
`define CPU900_STEPW 3

`endif

// ==== logic/cpu900_alu.sv ====
/* cpu900 ALU
   32-bit add, subtract, and, xor and move at byte, word or long width,
   with the flag updates for the register file */

`default_nettype none
`timescale 1ns/100ps

module cpu900_alu(
    input  wire cpu900_pkg::opcode_e op,
    input  wire cpu900_pkg::width_e  width,
    input  wire [31:0]               op0,
    input  wire [31:0]               op1,
    output logic [31:0]              rslt,
    output logic                     su,
    output logic                     zu,
    output logic                     hu,
    output logic                     vu,
    output logic                     nu,
    output logic                     cu
);
    import cpu900_pkg::*;

    logic [4:0]  sh;        // aligns the width's top bit with bit 31
    logic [31:0] a_al;
    logic [31:0] b_al;
    logic [31:0] r_al;
    logic [32:0] sum;
    logic [32:0] dif;
    logic [4:0]  hsum;
    logic [4:0]  hdif;
    logic        is_mov;

    always_comb begin
        case (width)
            W_BYTE:  sh = 5'd24;
            W_WORD:  sh = 5'd16;
            default: sh = 5'd0;
        endcase
        a_al = op0 << sh;
        b_al = op1 << sh;
        sum  = {1'b0, a_al} + {1'b0, b_al};
        dif  = {1'b0, a_al} - {1'b0, b_al};
        hsum = {1'b0, op0[3:0]} + {1'b0, op1[3:0]};
        hdif = {1'b0, op0[3:0]} - {1'b0, op1[3:0]};
    end

    always_comb begin
        r_al   = a_al;
        hu     = 1'b0;
        vu     = 1'b0;
        nu     = 1'b0;
        cu     = 1'b0;
        is_mov = 1'b0;
        case (op)
            OP_ADD: begin
                r_al = sum[31:0];
                cu   = sum[32];
                hu   = hsum[4];
                vu   = (a_al[31] == b_al[31]) && (sum[31] != a_al[31]);
            end
            OP_SUB, OP_CMP: begin
                r_al = dif[31:0];
                cu   = dif[32];             // borrow
                hu   = hdif[4];
                nu   = 1'b1;
                vu   = (a_al[31] != b_al[31]) && (dif[31] != a_al[31]);
            end
            OP_AND: begin
                r_al = a_al & b_al;
                hu   = 1'b1;
                vu   = ~^r_al;              // even parity
            end
            OP_XOR: begin
                r_al = a_al ^ b_al;
                vu   = ~^r_al;
            end
            default: is_mov = 1'b1;         // loads, store, srfp
        endcase
        su   = r_al[31];
        zu   = (r_al == 32'd0);
        rslt = is_mov ? op0 : (r_al >> sh);
    end

endmodule

`default_nettype wire

// ==== logic/cpu900_core.sv ====
/* cpu900 core
   micro-sequencer, register file and ALU; stored values leave on dout */

`default_nettype none
`timescale 1ns/100ps

module cpu900_core(
    input  wire        clk,
    input  wire        rst,
    input  wire        cen,
    input  wire [31:0] insn,
    input  wire        insn_stb,
    output wire        busy,
    output wire [31:0] dout,
    output wire        dout_we,
    output wire [7:0]  flags
);
    import cpu900_pkg::*;

    logic        md_ld;
    ral_e        ral_sel;
    rmux_e       rmux_sel;
    opnd_e       opnd_sel;
    ld_e         ld_sel;
    width_e      width;
    logic        sex;
    logic        flag_we;
    logic        alt_toggle;
    opcode_e     op;
    logic [31:0] op0;
    logic [31:0] op1;
    logic [31:0] rslt;
    logic        su;
    logic        zu;
    logic        hu;
    logic        vu;
    logic        nu;
    logic        cu;

    assign dout = op0;      // store data

    cpu900_seq seq_i(
        .clk(clk), .rst(rst), .cen(cen), .insn(insn), .insn_stb(insn_stb),
        .busy(busy), .dout_we(dout_we), .md_ld(md_ld), .ral_sel(ral_sel),
        .rmux_sel(rmux_sel), .opnd_sel(opnd_sel), .ld_sel(ld_sel), .width(width),
        .sex(sex), .flag_we(flag_we), .alt_toggle(alt_toggle), .op(op)
    );

    cpu900_regs regs_i(
        .clk(clk), .rst(rst), .cen(cen), .insn_word(insn), .md_ld(md_ld),
        .ral_sel(ral_sel), .rmux_sel(rmux_sel), .opnd_sel(opnd_sel), .ld_sel(ld_sel),
        .width(width), .sex(sex), .rslt(rslt), .su(su), .zu(zu), .hu(hu), .vu(vu),
        .nu(nu), .cu(cu), .flag_we(flag_we), .alt_toggle(alt_toggle),
        .op0(op0), .op1(op1), .flags(flags)
    );

    cpu900_alu alu_i(
        .op(op), .width(width), .op0(op0), .op1(op1), .rslt(rslt),
        .su(su), .zu(zu), .hu(hu), .vu(vu), .nu(nu), .cu(cu)
    );

endmodule

`default_nettype wire

// ==== logic/cpu900_pkg.sv ====
/* cpu900 shared types
   opcodes, operand widths, register file control selects and flag byte layout */

`default_nettype none

package cpu900_pkg;

    typedef enum logic [3:0] {
        OP_LDI  = 4'd0,     // load immediate
        OP_LD   = 4'd1,     // register to register
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_XOR  = 4'd5,
        OP_CMP  = 4'd6,     // sub without writeback
        OP_ST   = 4'd7,     // source to dout
        OP_SRFP = 4'd8,     // set bank pointer
        OP_EXF  = 4'd9      // swap flag set
    } opcode_e;

    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_WORD = 2'd1,
        W_LONG = 2'd2
    } width_e;

    // operand latch source
    typedef enum logic [3:0] {
        SRC_RMUX,
        DST_RMUX,
        IMM_RMUX,
        RFP_RMUX,
        FLAGS_RMUX,
        XSP_RMUX,
        ZERO_RMUX
    } rmux_e;

    // register address latch, SRC_RAL takes both codes
    typedef enum logic [1:0] { NONE_RAL, SRC_RAL, DST_RAL } ral_e;

    typedef enum logic [1:0] { NONE_OPND, LD0_OPND, LD1_OPND } opnd_e;

    typedef enum logic [2:0] { NONE_LD, DST_LD, RFP_LD, XSP_LD } ld_e;

    // bit positions inside the flag byte, 5 and 3 read zero
    typedef enum logic [2:0] {
        FLAG_C = 3'd0,
        FLAG_N = 3'd1,
        FLAG_V = 3'd2,
        FLAG_H = 3'd4,
        FLAG_Z = 3'd6,
        FLAG_S = 3'd7
    } flag_e;

    typedef struct packed {
        opcode_e    op;     // 31:28
        width_e     width;  // 27:26
        logic       sex;    // sign extend
        logic       rsv;
        logic [7:0] dst;    // 23:16
        logic [7:0] src;    // 15:8
        logic [7:0] imm;    // 7:0
    } insn_t;

endpackage

`default_nettype wire

// ==== logic/cpu900_regs.sv ====
/* cpu900 register file
   accumulators, pointers, bank pointer and flag sets, with register code decode,
   operand multiplexer, extension and partial writeback */

`default_nettype none
`timescale 1ns/100ps
`include "cpu900_config.svh"

module cpu900_regs(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cen,
    input  wire [31:0]              insn_word,
    input  wire                     md_ld,
    input  wire cpu900_pkg::ral_e   ral_sel,
    input  wire cpu900_pkg::rmux_e  rmux_sel,
    input  wire cpu900_pkg::opnd_e  opnd_sel,
    input  wire cpu900_pkg::ld_e    ld_sel,
    input  wire cpu900_pkg::width_e width,
    input  wire                     sex,
    input  wire [31:0]              rslt,
    input  wire                     su,
    input  wire                     zu,
    input  wire                     hu,
    input  wire                     vu,
    input  wire                     nu,
    input  wire                     cu,
    input  wire                     flag_we,
    input  wire                     alt_toggle,
    output logic [31:0]             op0,
    output logic [31:0]             op1,
    output logic [7:0]              flags
);
    import cpu900_pkg::*;

    insn_t       md;                        // instruction latch
    logic [7:0]  src;                       // absolute codes
    logic [7:0]  dst;
    logic [1:0]  rfp;                       // bank pointer
    logic [1:0]  prev_bank;
    logic        alt;                       // alternate flags in use
    logic [7:0]  flag_main;
    logic [7:0]  flag_alt;
    logic [7:0]  flag_new;
    logic [31:0] accs[`CPU900_NACC];
    logic [31:0] ptrs[`CPU900_NPTR];
    logic [7:0]  sd_code;
    logic [31:0] sd_reg;
    logic [4:0]  sd_sh;
    logic [31:0] rmux;
    logic [4:0]  wr_sh;
    logic [31:0] wr_mask;
    logic [31:0] dst_reg;
    logic [31:0] dst_new;

    // relative codes become absolute when latched
    function automatic logic [7:0] abs_code(
        input logic [7:0] code,
        input logic [1:0] bank,
        input logic [1:0] prev
    );
        logic [7:0] res;
        if (code[7]) begin
            res = code;                     // pointer
        end else begin
            case (code[6:4])
                3'b110:  res = {2'b00, bank, code[3:0]};
                3'b101:  res = {2'b00, prev, code[3:0]};
                default: res = {2'b00, code[5:0]};
            endcase
        end
        return res;
    endfunction

    // bit offset of the addressed part
    function automatic logic [4:0] part_sh(input logic [7:0] code, input width_e w);
        logic [4:0] sh;
        case (w)
            W_BYTE:  sh = {code[1:0], 3'd0};
            W_WORD:  sh = {code[1], 4'd0};
            default: sh = 5'd0;
        endcase
        return sh;
    endfunction

    assign prev_bank = rfp - 2'd1;          // wraps 0 to 3
    assign flags     = alt ? flag_alt : flag_main;

    always_comb begin
        sd_code = (rmux_sel == DST_RMUX) ? dst : src;
        sd_reg  = sd_code[7] ? ptrs[sd_code[3:2]] : accs[sd_code[5:2]];
        sd_sh   = part_sh(sd_code, width);
        case (rmux_sel)
            SRC_RMUX, DST_RMUX: rmux = sd_reg >> sd_sh;
            IMM_RMUX:   rmux = {24'd0, md.imm};
            RFP_RMUX:   rmux = {30'd0, rfp};
            FLAGS_RMUX: rmux = {24'd0, flags};
            XSP_RMUX:   rmux = ptrs[`CPU900_XSP];
            default:    rmux = 32'd0;
        endcase
        case (width)                        // zero or sign extension
            W_BYTE:  rmux[31:8]  = sex ? {24{rmux[7]}} : 24'd0;
            W_WORD:  rmux[31:16] = sex ? {16{rmux[15]}} : 16'd0;
            default: ;
        endcase
    end

    // merge the written part into the destination
    always_comb begin
        wr_sh = part_sh(dst, width);
        case (width)
            W_BYTE:  wr_mask = 32'h0000_00ff << wr_sh;
            W_WORD:  wr_mask = 32'h0000_ffff << wr_sh;
            default: wr_mask = 32'hffff_ffff;
        endcase
        dst_reg = dst[7] ? ptrs[dst[3:2]] : accs[dst[5:2]];
        dst_new = (dst_reg & ~wr_mask) | ((rslt << wr_sh) & wr_mask);
    end

    always_comb begin
        flag_new         = 8'd0;
        flag_new[FLAG_S] = su;
        flag_new[FLAG_Z] = zu;
        flag_new[FLAG_H] = hu;
        flag_new[FLAG_V] = vu;
        flag_new[FLAG_N] = nu;
        flag_new[FLAG_C] = cu;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            md        <= '0;
            src       <= 8'd0;
            dst       <= 8'd0;
            op0       <= 32'd0;
            op1       <= 32'd0;
            rfp       <= 2'd0;
            alt       <= 1'b0;
            flag_main <= 8'd0;
            flag_alt  <= 8'd0;
            for (int i = 0; i < `CPU900_NACC; i++) begin
                accs[i] <= 32'd0;
            end
            for (int i = 0; i < `CPU900_NPTR; i++) begin
                ptrs[i] <= 32'd0;
            end
        end else if (cen) begin
            if (md_ld) md <= insn_word;
            case (ral_sel)
                SRC_RAL: begin
                    src <= abs_code(md.src, rfp, prev_bank);
                    dst <= abs_code(md.dst, rfp, prev_bank);
                end
                DST_RAL: dst <= abs_code(md.dst, rfp, prev_bank);
                default: ;
            endcase
            case (opnd_sel)
                LD0_OPND: op0 <= rmux;
                LD1_OPND: op1 <= rmux;
                default: ;
            endcase
            case (ld_sel)
                DST_LD: begin
                    if (dst[7]) ptrs[dst[3:2]] <= dst_new;
                    else        accs[dst[5:2]] <= dst_new;
                end
                RFP_LD:  rfp <= rslt[1:0];
                XSP_LD:  ptrs[`CPU900_XSP] <= rslt;
                default: ;
            endcase
            if (flag_we) begin              // into the selected set
                if (alt) flag_alt  <= flag_new;
                else     flag_main <= flag_new;
            end
            if (alt_toggle) alt <= ~alt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu900_seq.sv ====
/* cpu900 micro-sequencer
   runs each accepted instruction through five fixed steps and drives the
   register file selects for every step */

`default_nettype none
`timescale 1ns/100ps
`include "cpu900_config.svh"

module cpu900_seq(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      cen,
    input  wire [31:0]               insn,
    input  wire                      insn_stb,
    output logic                     busy,
    output logic                     dout_we,
    output logic                     md_ld,
    output cpu900_pkg::ral_e         ral_sel,
    output cpu900_pkg::rmux_e        rmux_sel,
    output cpu900_pkg::opnd_e        opnd_sel,
    output cpu900_pkg::ld_e          ld_sel,
    output cpu900_pkg::width_e       width,
    output logic                     sex,
    output logic                     flag_we,
    output logic                     alt_toggle,
    output cpu900_pkg::opcode_e      op
);
    import cpu900_pkg::*;

    localparam logic [`CPU900_STEPW-1:0] S_RAL = `CPU900_STEPW'd0;
    localparam logic [`CPU900_STEPW-1:0] S_OP0 = `CPU900_STEPW'd1;
    localparam logic [`CPU900_STEPW-1:0] S_OP1 = `CPU900_STEPW'd2;
    localparam logic [`CPU900_STEPW-1:0] S_EXE = `CPU900_STEPW'd3;
    localparam logic [`CPU900_STEPW-1:0] S_WB  = `CPU900_STEPW'(`CPU900_STEPS - 1);

    insn_t                    in_w;
    logic [`CPU900_STEPW-1:0] step;
    logic                     two_op;   // dst and src operands

    assign in_w   = insn;
    assign md_ld  = insn_stb & ~busy & cen;
    assign two_op = op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_CMP};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            step  <= S_RAL;
            op    <= OP_LDI;
            width <= W_BYTE;
            sex   <= 1'b0;
        end else if (cen) begin
            if (md_ld) begin
                busy  <= 1'b1;
                step  <= S_RAL;
                op    <= in_w.op;
                width <= in_w.width;
                sex   <= in_w.sex;
            end else if (busy) begin
                if (step == S_WB) busy <= 1'b0;
                step <= step + 1'b1;
            end
        end
    end

    always_comb begin
        ral_sel    = NONE_RAL;
        rmux_sel   = ZERO_RMUX;
        opnd_sel   = NONE_OPND;
        ld_sel     = NONE_LD;
        flag_we    = 1'b0;
        alt_toggle = 1'b0;
        dout_we    = 1'b0;
        if (busy) begin
            case (step)
                S_RAL: begin
                    case (op)
                        OP_LDI:          ral_sel = DST_RAL;
                        OP_SRFP, OP_EXF: ral_sel = NONE_RAL;
                        default:         ral_sel = SRC_RAL;
                    endcase
                end
                S_OP0: begin
                    opnd_sel = LD0_OPND;
                    case (op)
                        OP_LDI, OP_SRFP: rmux_sel = IMM_RMUX;
                        OP_LD, OP_ST:    rmux_sel = SRC_RMUX;
                        OP_EXF:          opnd_sel = NONE_OPND;
                        default:         rmux_sel = DST_RMUX;
                    endcase
                end
                S_OP1: begin
                    if (two_op) begin
                        opnd_sel = LD1_OPND;
                        rmux_sel = SRC_RMUX;
                    end
                end
                S_EXE: dout_we = cen & (op == OP_ST);   // dout shows op0 now
                S_WB: begin
                    flag_we = two_op;
                    case (op)
                        OP_LDI, OP_LD, OP_ADD,
                        OP_SUB, OP_AND, OP_XOR: ld_sel = DST_LD;
                        OP_SRFP:                ld_sel = RFP_LD;
                        OP_EXF:                 alt_toggle = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verif/cpu900_assertions.sv ====
/* cpu900 protocol assertions
   busy after reset, store pulse inside busy, five-step busy length */

`default_nettype none
`timescale 1ns/100ps

module cpu900_assertions(
    input wire clk,
    input wire rst,
    input wire cen,
    input wire busy,
    input wire dout_we
);

    // idle right after reset release
    property busy_low_after_reset;
        @(posedge clk) $fell(rst) |-> !busy;
    endproperty

    // store data leaves mid-instruction after the operand steps
    property dout_we_in_busy;
        @(posedge clk) disable iff (rst) dout_we |-> busy && $past(busy, 3) ##1 busy;
    endproperty

    // five steps when never stalled
    property busy_five_cycles;
        @(posedge clk) disable iff (rst)
            ($rose(busy) && cen ##1 cen ##1 cen ##1 cen ##1 cen) |-> busy ##1 !busy;
    endproperty

    reset_chk: assert property (busy_low_after_reset)
        else $error("busy high after reset");

    we_chk: assert property (dout_we_in_busy)
        else $error("dout_we outside the execute step of an instruction");

    len_chk: assert property (busy_five_cycles)
        else $error("busy length differs from five steps");

endmodule

`default_nettype wire

// ==== verif/cpu900_tb.sv ====
/* cpu900 testbench
   reference model of the register file and ALU, directed and random programs,
   store and flag checks */

`default_nettype none
`timescale 1ns/100ps
`include "cpu900_config.svh"

module cpu900_tb;
    import cpu900_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_DIRECTED = 200;
    localparam int N_RANDOM   = 300;

    logic        clk = 1'b0;
    logic        rst;
    logic        cen;
    logic [31:0] insn;
    logic        insn_stb;
    wire         busy;
    wire  [31:0] dout;
    wire         dout_we;
    wire  [7:0]  flags;

    integer      seed = 32'h3bc1cd44;
    logic [31:0] m_reg[`CPU900_NACC + `CPU900_NPTR];  // accumulators, then pointers
    logic [1:0]  m_rfp;
    logic        m_alt;
    logic [7:0]  m_flag[2];
    logic [31:0] exp_dout;
    logic        st_pending;
    logic        stall_mode;                // random cen and junk strobes

    cpu900_core dut_i(
        .clk(clk), .rst(rst), .cen(cen), .insn(insn), .insn_stb(insn_stb),
        .busy(busy), .dout(dout), .dout_we(dout_we), .flags(flags)
    );

    bind cpu900_core cpu900_assertions assert_i(
        .clk(clk), .rst(rst), .cen(cen), .busy(busy), .dout_we(dout_we)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] e, input logic [31:0] a);
        $display("ERROR %0t %s expected %h actual %h", $time, name, e, a);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic int reg_index(input logic [7:0] code);
        logic [1:0] prev;
        prev = m_rfp - 2'd1;
        if (code[7]) return `CPU900_NACC + code[3:2];
        case (code[6:4])
            3'b110:  return {m_rfp, code[3:2]};
            3'b101:  return {prev, code[3:2]};
            default: return code[5:2];
        endcase
    endfunction

    function automatic logic [31:0] width_mask(input width_e w);
        return (w == W_BYTE) ? 32'hff : (w == W_WORD) ? 32'hffff : 32'hffff_ffff;
    endfunction

    function automatic int part_shift(input logic [7:0] code, input width_e w);
        return (w == W_BYTE) ? code[1:0] * 8 : (w == W_WORD) ? code[1] * 16 : 0;
    endfunction

    function automatic logic [31:0] extend(input logic [31:0] v, input width_e w, input logic sx);
        logic [31:0] m;
        m = width_mask(w);
        v = v & m;
        if (sx && w != W_LONG && v[(w == W_BYTE) ? 7 : 15]) v = v | ~m;
        return v;
    endfunction

    function automatic logic [31:0] read_part(input logic [7:0] code, input width_e w,
                                              input logic sx);
        return extend(m_reg[reg_index(code)] >> part_shift(code, w), w, sx);
    endfunction

    task automatic write_part(input logic [7:0] code, input width_e w, input logic [31:0] v);
        int          idx;
        logic [31:0] m;
        idx = reg_index(code);
        m = width_mask(w) << part_shift(code, w);
        m_reg[idx] = (m_reg[idx] & ~m) | ((v << part_shift(code, w)) & m);
    endtask

    // flag rules worked on the masked operands
    task automatic alu_ref(input opcode_e op, input width_e w, input logic [31:0] x,
                           input logic [31:0] y, output logic [31:0] r, output logic [7:0] f);
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] full;
        int          t;
        a = x & width_mask(w);
        b = y & width_mask(w);
        t = (w == W_BYTE) ? 7 : (w == W_WORD) ? 15 : 31;
        f = 8'd0;
        case (op)
            OP_ADD: begin
                full = {1'b0, a} + {1'b0, b};
                r = full[31:0] & width_mask(w);
                f[FLAG_C] = full[t + 1];
                f[FLAG_H] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
                f[FLAG_V] = (a[t] == b[t]) && (r[t] != a[t]);
            end
            OP_SUB, OP_CMP: begin
                r = (a - b) & width_mask(w);
                f[FLAG_C] = a < b;
                f[FLAG_H] = a[3:0] < b[3:0];
                f[FLAG_N] = 1'b1;
                f[FLAG_V] = (a[t] != b[t]) && (r[t] != a[t]);
            end
            OP_AND: begin
                r = a & b;
                f[FLAG_H] = 1'b1;
                f[FLAG_V] = ~^r;
            end
            default: begin
                r = a ^ b;
                f[FLAG_V] = ~^r;
            end
        endcase
        f[FLAG_S] = r[t];
        f[FLAG_Z] = (r == 32'd0);
    endtask

    task automatic model(input opcode_e op, input width_e w, input logic sx,
                         input logic [7:0] dst, input logic [7:0] src, input logic [7:0] imm);
        logic [31:0] r;
        logic [7:0]  f;
        case (op)
            OP_LDI:  write_part(dst, w, extend({24'd0, imm}, w, sx));
            OP_LD:   write_part(dst, w, read_part(src, w, sx));
            OP_ST: begin
                exp_dout   = read_part(src, w, sx);
                st_pending = 1'b1;
            end
            OP_SRFP: m_rfp = imm[1:0];
            OP_EXF:  m_alt = ~m_alt;
            default: begin
                alu_ref(op, w, read_part(dst, w, sx), read_part(src, w, sx), r, f);
                if (op != OP_CMP) write_part(dst, w, r);
                m_flag[m_alt] = f;
            end
        endcase
    endtask

    // one instruction from issue to the end of writeback
    task automatic exec(input opcode_e op, input width_e w, input logic sx,
                        input logic [7:0] dst, input logic [7:0] src, input logic [7:0] imm);
        model(op, w, sx, dst, src, imm);
        insn     = {op, w, sx, 1'b0, dst, src, imm};
        insn_stb = 1'b1;
        cen      = 1'b1;
        @(posedge clk);
        #1;
        insn_stb = 1'b0;
        while (busy) begin
            if (stall_mode) begin
                cen      = ($unsigned($random(seed)) % 4) != 0;
                insn_stb = $random(seed);
                insn     = $random(seed);   // ignored while busy
            end
            @(posedge clk);
            #1;
        end
        insn_stb = 1'b0;
        cen      = 1'b1;
        assert (flags == m_flag[m_alt])
            else report_mismatch("flags", m_flag[m_alt], flags);
        assert (!st_pending)
            else report_failure("store finished without a dout_we pulse");
    endtask

    task automatic load_long(input logic [7:0] code, input logic [31:0] v);
        for (int k = 0; k < 4; k++) begin
            exec(OP_LDI, W_BYTE, 1'b0, code | k[7:0], 8'd0, v[8 * k +: 8]);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && dout_we) begin
            assert (st_pending)
                else report_failure("dout_we pulse without a pending store");
            assert (dout == exp_dout)
                else report_mismatch("dout", exp_dout, dout);
            st_pending = 1'b0;
        end
    end

    initial begin
        #(((N_DIRECTED + N_RANDOM) * 12 + 16) * CLK_PERIOD);
        $display("%0t: watchdog expired, the DUT stopped finishing instructions", $time);
        $display("RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        logic [31:0] pa[3];
        logic [31:0] pb[3];
        logic [7:0]  dc[3];
        logic [7:0]  sc[3];
        rst        = 1'b1;
        cen        = 1'b1;
        insn       = 32'd0;
        insn_stb   = 1'b0;
        stall_mode = 1'b0;
        st_pending = 1'b0;
        exp_dout   = 32'd0;
        m_rfp      = 2'd0;
        m_alt      = 1'b0;
        m_flag[0]  = 8'd0;
        m_flag[1]  = 8'd0;
        for (int i = 0; i < `CPU900_NACC + `CPU900_NPTR; i++) m_reg[i] = 32'd0;
        pa = '{32'h1122_3388, 32'h7ff9_2468, 32'h8000_0000};
        pb = '{32'h5566_7788, 32'h0007_1357, 32'h8000_0001};
        dc = '{8'h11, 8'h12, 8'h10};        // byte lane 1, upper word, long
        sc = '{8'h16, 8'h16, 8'h14};
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // every register reads zero after reset
        for (int i = 0; i < `CPU900_NACC; i++) begin
            exec(OP_ST, W_LONG, 1'b0, 8'd0, i << 2, 8'd0);
        end
        for (int p = 0; p < `CPU900_NPTR; p++) begin
            exec(OP_ST, W_LONG, 1'b0, 8'd0, 8'h80 | (p << 2), 8'd0);
        end

        // partial loads and merged stores
        exec(OP_LDI, W_LONG, 1'b0, 8'h04, 8'd0, 8'ha5);
        exec(OP_LDI, W_BYTE, 1'b0, 8'h05, 8'd0, 8'h3c);
        exec(OP_LDI, W_BYTE, 1'b1, 8'h07, 8'd0, 8'h81);
        exec(OP_LDI, W_WORD, 1'b1, 8'h0a, 8'd0, 8'hf0);
        exec(OP_LD, W_WORD, 1'b0, 8'h0a, 8'h04, 8'd0);
        exec(OP_LD, W_BYTE, 1'b1, 8'h08, 8'h07, 8'd0);
        exec(OP_LD, W_LONG, 1'b0, 8'h8c, 8'h04, 8'd0);
        exec(OP_ST, W_LONG, 1'b0, 8'd0, 8'h04, 8'd0);
        exec(OP_ST, W_LONG, 1'b0, 8'd0, 8'h08, 8'd0);
        exec(OP_ST, W_BYTE, 1'b1, 8'd0, 8'h07, 8'd0);
        exec(OP_ST, W_WORD, 1'b1, 8'd0, 8'h06, 8'd0);
        exec(OP_ST, W_LONG, 1'b0, 8'd0, 8'h8c, 8'd0);

        // ALU ops at every width
        for (int w = 0; w < 3; w++) begin
            for (int o = OP_ADD; o <= OP_CMP; o++) begin
                load_long(8'h10, pa[w]);
                load_long(8'h14, pb[w]);
                exec(opcode_e'(o), width_e'(w), 1'b0, dc[w], sc[w], 8'd0);
                exec(OP_ST, W_LONG, 1'b0, 8'd0, 8'h10, 8'd0);
            end
        end

        // bank-relative codes, with the wrap from bank 0
        exec(OP_SRFP, W_BYTE, 1'b0, 8'd0, 8'd0, 8'h01);
        exec(OP_LDI, W_LONG, 1'b0, 8'h64, 8'd0, 8'h11);
        exec(OP_LDI, W_LONG, 1'b0, 8'h58, 8'd0, 8'h22);
        exec(OP_SRFP, W_BYTE, 1'b0, 8'd0, 8'd0, 8'h00);
        exec(OP_LDI, W_LONG, 1'b0, 8'h5c, 8'd0, 8'h33);
        exec(OP_ST, W_LONG, 1'b0, 8'd0, 8'h14, 8'd0);
        exec(OP_ST, W_LONG, 1'b0, 8'd0, 8'h08, 8'd0);
        exec(OP_ST, W_LONG, 1'b0, 8'd0, 8'h3c, 8'd0);

        // alternate flag set
        exec(OP_SUB, W_BYTE, 1'b0, 8'h00, 8'h04, 8'd0);
        exec(OP_EXF, W_BYTE, 1'b0, 8'd0, 8'd0, 8'd0);
        exec(OP_CMP, W_LONG, 1'b0, 8'h04, 8'h04, 8'd0);
        exec(OP_EXF, W_BYTE, 1'b0, 8'd0, 8'd0, 8'd0);

        // random program with stalls and junk strobes
        stall_mode = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            exec(opcode_e'($unsigned($random(seed)) % 10), width_e'($unsigned($random(seed)) % 3),
                 $random(seed), $random(seed), $random(seed), $random(seed));
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
